/* ddr_buf_pkg.sv */
package ddr_buf_pkg;

  // ========================================
  // widths and sizes
  // ========================================
  localparam int DWIDTH    = 16;
  localparam int BWIDTH    = 64;
  localparam int RATE      = BWIDTH / DWIDTH;
  localparam int RATELOG   = 2;
  localparam int BURST_LEN = 8;
  localparam int BUFSIZE   = 3;
  localparam int IMGSIZE   = 16;
  localparam int LWIDTH    = 16;

  // ddr mode bit
  localparam logic DDR_READ  = 1'b0;
  localparam logic DDR_WRITE = 1'b1;

  // wishbone register map
  localparam logic [1:0] REG_BASE   = 2'd0;
  localparam logic [1:0] REG_LEN    = 2'd1;
  localparam logic [1:0] REG_CTRL   = 2'd2;
  localparam logic [1:0] REG_STATUS = 2'd3;

  // ========================================
  // types
  // ========================================
  typedef logic [DWIDTH-1:0]  word_t;
  typedef logic [BWIDTH-1:0]  beat_t;
  typedef logic [IMGSIZE-1:0] addr_t;
  typedef logic [LWIDTH-1:0]  len_t;
  typedef logic [BUFSIZE-1:0] buf_addr_t;

  typedef enum logic [1:0] {S_IDLE, S_PREF, S_WRITE} ctrl_state_t;

  // memory facing the word port
  typedef enum logic [1:0] {SEL_PREF, SEL_ALPHA, SEL_BRAVO} bank_sel_t;

  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [1:0]  adr;
    logic [31:0] dat_w;
  } wb_req_t;

  typedef struct packed {
    logic        ack;
    logic [31:0] dat_r;
  } wb_rsp_t;

  typedef struct packed {
    addr_t base;
    len_t  len;
  } cfg_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    word_t wdata;
  } mem_port_t;

  typedef struct packed {
    logic  req;
    logic  mode;
    addr_t base;
    len_t  len;
  } ddr_cmd_t;

  typedef struct packed {
    logic  we;
    addr_t addr;
    beat_t wdata;
  } ddr_beat_t;

  typedef struct packed {
    bank_sel_t          sel;
    logic               pref_we;
    logic               fill_we;
    buf_addr_t          pref_addr;
    buf_addr_t          fill_addr;
    buf_addr_t          drain_addr;
    logic [RATELOG-1:0] word_sel;
  } bank_ctl_t;

endpackage

/* ddr_buf_regs.sv */
module ddr_buf_regs
  import ddr_buf_pkg::*;
(
  input  logic    clk,
  input  logic    xrst,
  input  wb_req_t wb_i,
  output wb_rsp_t wb_o,
  input  logic    busy,
  output cfg_t    cfg,
  output logic    start_pref,
  output logic    start_write
);

  logic        access;
  logic        wr;
  logic        r_ack;
  logic [31:0] r_dat_r;
  addr_t       r_base;
  len_t        r_len;

  // single access, a new one only after ack has dropped
  assign access = wb_i.cyc && wb_i.stb && !r_ack;
  assign wr     = access && wb_i.we;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_ack <= 1'b0;
    end else begin
      r_ack <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_base <= '0;
      r_len  <= '0;
    end else if (wr && wb_i.adr == REG_BASE) begin
      r_base <= addr_t'(wb_i.dat_w);
    end else if (wr && wb_i.adr == REG_LEN) begin
      r_len <= len_t'(wb_i.dat_w);
    end
  end

  // start pulses line up with ack
  always_ff @(posedge clk) begin
    if (!xrst) begin
      start_pref  <= 1'b0;
      start_write <= 1'b0;
    end else begin
      start_pref  <= wr && wb_i.adr == REG_CTRL && wb_i.dat_w[0] && !busy;
      start_write <= wr && wb_i.adr == REG_CTRL && wb_i.dat_w[1] && !busy;
    end
  end

  always_ff @(posedge clk) begin
    if (access && !wb_i.we) begin
      case (wb_i.adr)
        REG_BASE:   r_dat_r <= 32'(r_base);
        REG_LEN:    r_dat_r <= 32'(r_len);
        REG_STATUS: r_dat_r <= {31'd0, busy};
        default:    r_dat_r <= '0;
      endcase
    end
  end

  assign wb_o = '{ack: r_ack, dat_r: r_dat_r};
  assign cfg  = '{base: r_base, len: r_len};

endmodule

/* ddr_buf_ctrl.sv */
module ddr_buf_ctrl
  import ddr_buf_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  cfg_t      cfg,
  input  logic      start_pref,
  input  logic      start_write,
  input  logic      beat_valid,
  input  ddr_beat_t ddr_beat,
  output logic      busy,
  output ddr_cmd_t  ddr_cmd,
  output bank_ctl_t bank,
  input  addr_t     mem_addr
);

  ctrl_state_t        state;
  bank_sel_t          r_sel;
  ddr_cmd_t           r_cmd;
  addr_t              r_job_base;
  len_t               r_words_left;
  len_t               r_rx_cnt;
  buf_addr_t          r_fill_cnt;
  len_t               r_burst_cnt;
  logic [RATELOG-1:0] r_word_sel;
  len_t               cur_beats;
  addr_t              pref_wr_off;
  addr_t              pref_rd_off;
  addr_t              drain_off;
  logic               job_start;
  logic               pref_last;
  logic               fill_we;
  logic               burst_end;
  logic               job_done;

  // beats in the next burst, short only at the tail
  function automatic len_t burst_beats(len_t words);
    if (words >= len_t'(RATE * BURST_LEN)) begin
      return len_t'(BURST_LEN);
    end
    return words >> RATELOG;
  endfunction

  // ========================================
  // job control
  // ========================================
  assign job_start = state == S_IDLE && (start_pref || start_write);
  assign cur_beats = burst_beats(r_words_left);
  assign pref_last = state == S_PREF && ddr_beat.we && r_rx_cnt + 1 == r_cmd.len;
  assign fill_we   = state == S_WRITE && beat_valid;
  assign burst_end = fill_we && len_t'(r_fill_cnt) + 1 == cur_beats;
  // hold busy through the last write request
  assign job_done  = state == S_WRITE && r_cmd.req && r_words_left == '0;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (start_pref) begin
            state <= S_PREF;
          end else if (start_write) begin
            state <= S_WRITE;
          end
        end
        S_PREF: begin
          if (pref_last) begin
            state <= S_IDLE;
          end
        end
        S_WRITE: begin
          if (job_done) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_job_base   <= '0;
      r_words_left <= '0;
      r_sel        <= SEL_PREF;
    end else if (job_start) begin
      r_job_base   <= cfg.base >> RATELOG;
      r_words_left <= cfg.len;
      r_sel        <= start_pref ? SEL_PREF : SEL_ALPHA;
    end else if (burst_end) begin
      // filled memory turns to ddr, the other one takes words
      r_words_left <= r_words_left - (cur_beats << RATELOG);
      r_sel        <= (r_sel == SEL_ALPHA) ? SEL_BRAVO : SEL_ALPHA;
    end
  end

  // counters clear while idle
  always_ff @(posedge clk) begin
    if (!xrst || state == S_IDLE) begin
      r_rx_cnt    <= '0;
      r_fill_cnt  <= '0;
      r_burst_cnt <= '0;
    end else begin
      if (state == S_PREF && ddr_beat.we) begin
        r_rx_cnt <= r_rx_cnt + 1'b1;
      end
      if (burst_end) begin
        r_fill_cnt  <= '0;
        r_burst_cnt <= r_burst_cnt + 1'b1;
      end else if (fill_we) begin
        r_fill_cnt <= r_fill_cnt + 1'b1;
      end
    end
  end

  // ========================================
  // ddr command
  // ========================================
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_cmd <= '0;
    end else begin
      r_cmd.req <= 1'b0;
      if (state == S_IDLE && start_pref) begin
        r_cmd.req  <= 1'b1;
        r_cmd.mode <= DDR_READ;
        r_cmd.base <= cfg.base >> RATELOG;
        r_cmd.len  <= burst_beats(cfg.len);
      end else if (burst_end) begin
        r_cmd.req  <= 1'b1;
        r_cmd.mode <= DDR_WRITE;
        r_cmd.base <= r_job_base + addr_t'(r_burst_cnt * BURST_LEN);
        r_cmd.len  <= cur_beats;
      end
    end
  end

  assign ddr_cmd = r_cmd;
  assign busy    = state != S_IDLE;

  // ========================================
  // memory steering
  // ========================================
  assign pref_wr_off = ddr_beat.addr - r_job_base;
  assign pref_rd_off = (mem_addr >> RATELOG) - r_job_base;
  assign drain_off   = ddr_beat.addr - r_cmd.base;

  // word select lines up with the read data
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_word_sel <= '0;
    end else begin
      r_word_sel <= mem_addr[RATELOG-1:0];
    end
  end

  always_comb begin
    bank.sel        = r_sel;
    bank.pref_we    = state == S_PREF && ddr_beat.we;
    bank.fill_we    = fill_we;
    bank.pref_addr  = (state == S_PREF) ? buf_addr_t'(pref_wr_off) : buf_addr_t'(pref_rd_off);
    bank.fill_addr  = r_fill_cnt;
    bank.drain_addr = buf_addr_t'(drain_off);
    bank.word_sel   = r_word_sel;
  end

endmodule

/* word_packer.sv */
module word_packer
  import ddr_buf_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  mem_port_t mem,
  output logic      beat_valid,
  output beat_t     beat
);

  logic [RATELOG-1:0] r_cnt;
  beat_t              r_beat;

  // newest word enters at the top, word 0 ends in the low slice
  always_ff @(posedge clk) begin
    if (mem.we) begin
      r_beat <= {mem.wdata, r_beat[BWIDTH-1:DWIDTH]};
    end
  end

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_cnt      <= '0;
      beat_valid <= 1'b0;
    end else begin
      beat_valid <= mem.we && r_cnt == RATELOG'(RATE - 1);
      if (mem.we) begin
        r_cnt <= r_cnt + 1'b1;
      end
    end
  end

  assign beat = r_beat;

endmodule

/* sp_ram.sv */
module sp_ram
  import ddr_buf_pkg::*;
(
  input  logic      clk,
  input  logic      we,
  input  buf_addr_t addr,
  input  beat_t     wdata,
  output beat_t     rdata
);

  beat_t mem [BURST_LEN];

  // read returns the old word on a write
  always_ff @(posedge clk) begin
    if (we) begin
      mem[addr] <= wdata;
    end
    rdata <= mem[addr];
  end

endmodule

/* burst_bank.sv */
module burst_bank
  import ddr_buf_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  bank_ctl_t bank,
  input  beat_t     beat,
  input  beat_t     ddr_wdata,
  output word_t     mem_rdata,
  output beat_t     ddr_rdata
);

  logic      alpha_we;
  logic      bravo_we;
  buf_addr_t alpha_addr;
  buf_addr_t bravo_addr;
  beat_t     pref_rdata;
  beat_t     alpha_rdata;
  beat_t     bravo_rdata;
  beat_t     word_beat;
  bank_sel_t r_sel;

  // ========================================
  // ping-pong routing
  // ========================================
  // word-port side fills, the other side drains
  assign alpha_we   = bank.fill_we && bank.sel == SEL_ALPHA;
  assign bravo_we   = bank.fill_we && bank.sel == SEL_BRAVO;
  assign alpha_addr = (bank.sel == SEL_ALPHA) ? bank.fill_addr : bank.drain_addr;
  assign bravo_addr = (bank.sel == SEL_BRAVO) ? bank.fill_addr : bank.drain_addr;

  sp_ram u_pref (
    .clk   (clk),
    .we    (bank.pref_we),
    .addr  (bank.pref_addr),
    .wdata (ddr_wdata),
    .rdata (pref_rdata)
  );

  sp_ram u_alpha (
    .clk   (clk),
    .we    (alpha_we),
    .addr  (alpha_addr),
    .wdata (beat),
    .rdata (alpha_rdata)
  );

  sp_ram u_bravo (
    .clk   (clk),
    .we    (bravo_we),
    .addr  (bravo_addr),
    .wdata (beat),
    .rdata (bravo_rdata)
  );

  // ========================================
  // read side
  // ========================================
  // data comes a cycle after the address, so the mux follows a delayed select
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_sel <= SEL_PREF;
    end else begin
      r_sel <= bank.sel;
    end
  end

  always_comb begin
    case (r_sel)
      SEL_ALPHA: begin
        word_beat = alpha_rdata;
        ddr_rdata = bravo_rdata;
      end
      SEL_BRAVO: begin
        word_beat = bravo_rdata;
        ddr_rdata = alpha_rdata;
      end
      default: begin
        word_beat = pref_rdata;
        ddr_rdata = pref_rdata;
      end
    endcase
  end

  assign mem_rdata = word_beat[bank.word_sel*DWIDTH +: DWIDTH];

endmodule

/* ddr_buf_top.sv */
module ddr_buf_top
  import ddr_buf_pkg::*;
(
  input  logic      clk,
  input  logic      xrst,
  input  wb_req_t   wb_i,
  output wb_rsp_t   wb_o,
  input  mem_port_t mem,
  output word_t     mem_rdata,
  output ddr_cmd_t  ddr_cmd,
  input  ddr_beat_t ddr_beat,
  output beat_t     ddr_rdata
);

  cfg_t      cfg;
  logic      busy;
  logic      start_pref;
  logic      start_write;
  logic      beat_valid;
  beat_t     beat;
  bank_ctl_t bank;

  ddr_buf_regs u_regs (
    .clk         (clk),
    .xrst        (xrst),
    .wb_i        (wb_i),
    .wb_o        (wb_o),
    .busy        (busy),
    .cfg         (cfg),
    .start_pref  (start_pref),
    .start_write (start_write)
  );

  ddr_buf_ctrl u_ctrl (
    .clk         (clk),
    .xrst        (xrst),
    .cfg         (cfg),
    .start_pref  (start_pref),
    .start_write (start_write),
    .beat_valid  (beat_valid),
    .ddr_beat    (ddr_beat),
    .busy        (busy),
    .ddr_cmd     (ddr_cmd),
    .bank        (bank),
    .mem_addr    (mem.addr)
  );

  word_packer u_packer (
    .clk        (clk),
    .xrst       (xrst),
    .mem        (mem),
    .beat_valid (beat_valid),
    .beat       (beat)
  );

  burst_bank u_bank (
    .clk       (clk),
    .xrst      (xrst),
    .bank      (bank),
    .beat      (beat),
    .ddr_wdata (ddr_beat.wdata),
    .mem_rdata (mem_rdata),
    .ddr_rdata (ddr_rdata)
  );

endmodule

/* tb_clkgen.sv */
module tb_clkgen (
  output logic clk,
  output logic xrst
);

  localparam int PERIOD     = 10;
  localparam int RST_CYCLES = 16;

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released on a rising edge
  initial begin
    xrst = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    xrst <= 1'b1;
  end

endmodule

/* ddr_buf_assert.sv */
module ddr_buf_assert
  import ddr_buf_pkg::*;
(
  input logic        clk,
  input logic        xrst,
  input ctrl_state_t state,
  input logic        busy,
  input ddr_cmd_t    ddr_cmd,
  input ddr_beat_t   ddr_beat
);

  int fail_cnt = 0;

  // ========================================
  // controller rules
  // ========================================
  req_one_cycle: assert property (@(posedge clk) disable iff (!xrst)
    ddr_cmd.req |=> !ddr_cmd.req)
    else begin
      fail_cnt++;
      $error("ddr request held for more than one cycle");
    end

  // no read beat may arrive without a prefetch job
  no_beat_idle: assert property (@(posedge clk) disable iff (!xrst)
    state == S_IDLE |-> !ddr_beat.we)
    else begin
      fail_cnt++;
      $error("ddr beat written while the controller is idle");
    end

  // busy drops only after the last read beat or the last write request
  busy_fall: assert property (@(posedge clk) disable iff (!xrst)
    $fell(busy) |-> $past(ddr_beat.we) || $past(ddr_cmd.req && ddr_cmd.mode == DDR_WRITE))
    else begin
      fail_cnt++;
      $error("busy fell without a last read beat or a write request");
    end

endmodule

bind ddr_buf_ctrl ddr_buf_assert u_assert (
  .clk      (clk),
  .xrst     (xrst),
  .state    (state),
  .busy     (busy),
  .ddr_cmd  (ddr_cmd),
  .ddr_beat (ddr_beat)
);

/* tb_ddr_buf.sv */
module tb_ddr_buf
  import ddr_buf_pkg::*;
();

  // tests take about 700 cycles, the limit leaves a wide margin
  localparam int MAX_CYCLES = 5000;

  logic      clk;
  logic      xrst;
  wb_req_t   wb_i;
  wb_rsp_t   wb_o;
  mem_port_t mem;
  word_t     mem_rdata;
  ddr_cmd_t  ddr_cmd;
  ddr_beat_t ddr_beat;
  beat_t     ddr_rdata;

  integer   seed = 32'h88aa_83ef;
  int       cycle_cnt = 0;
  int       err_cnt = 0;
  int       check_cnt = 0;
  int       test_cnt = 0;
  int       served = 0;
  beat_t    ddr_mem [256];
  beat_t    drained [256];
  word_t    sent_words [64];
  ddr_cmd_t cmd_log [$];
  ddr_cmd_t pending [$];
  ddr_cmd_t srv_cmd;

  tb_clkgen u_clkgen (
    .clk  (clk),
    .xrst (xrst)
  );

  ddr_buf_top u_dut (
    .clk       (clk),
    .xrst      (xrst),
    .wb_i      (wb_i),
    .wb_o      (wb_o),
    .mem       (mem),
    .mem_rdata (mem_rdata),
    .ddr_cmd   (ddr_cmd),
    .ddr_beat  (ddr_beat),
    .ddr_rdata (ddr_rdata)
  );

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      $display("timeout: run stopped after %0d cycles", cycle_cnt);
      $display("*** FAILED ***");
      $finish;
    end
  end

  // ========================================
  // ddr master model
  // ========================================
  always @(negedge clk) begin
    if (xrst && ddr_cmd.req) begin
      cmd_log.push_back(ddr_cmd);
      pending.push_back(ddr_cmd);
    end
  end

  // read beats after a random latency
  task automatic serve_read(input ddr_cmd_t cmd);
    int    lat;
    addr_t a;
    lat = 1 + ($random(seed) & 3);
    repeat (lat) @(posedge clk);
    for (int i = 0; i < int'(cmd.len); i++) begin
      a = cmd.base + addr_t'(i);
      ddr_beat <= '{we: 1'b1, addr: a, wdata: ddr_mem[a[7:0]]};
      @(posedge clk);
    end
    ddr_beat <= '0;
  endtask

  // data comes back one cycle after each address
  task automatic serve_write(input ddr_cmd_t cmd);
    addr_t a;
    for (int i = 0; i <= int'(cmd.len); i++) begin
      if (i < int'(cmd.len)) begin
        ddr_beat <= '{we: 1'b0, addr: cmd.base + addr_t'(i), wdata: '0};
      end else begin
        ddr_beat <= '0;
      end
      if (i > 0) begin
        @(negedge clk);
        a = cmd.base + addr_t'(i - 1);
        drained[a[7:0]] = ddr_rdata;
      end
      @(posedge clk);
    end
  endtask

  initial begin
    ddr_beat = '0;
    forever begin
      @(posedge clk);
      if (pending.size() != 0) begin
        srv_cmd = pending.pop_front();
        if (srv_cmd.mode == DDR_READ) begin
          serve_read(srv_cmd);
        end else begin
          serve_write(srv_cmd);
        end
        served++;
      end
    end
  end

  // ========================================
  // helpers
  // ========================================
  task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
    check_cnt++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s got %0h expected %0h", $time, name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic wb_xfer(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                         output logic [31:0] rdata);
    int n;
    n = 0;
    @(posedge clk);
    wb_i <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: wdata};
    @(negedge clk);
    while (!wb_o.ack && n < 20) begin
      @(negedge clk);
      n++;
    end
    if (!wb_o.ack) begin
      $display("ERROR at %0t: no Wishbone ack for register %0d", $time, adr);
      err_cnt++;
    end
    rdata = wb_o.dat_r;
    @(posedge clk);
    wb_i <= '0;
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdata);
    logic [31:0] unused;
    wb_xfer(1'b1, adr, wdata, unused);
  endtask

  task automatic wb_read(input logic [1:0] adr, output logic [31:0] rdata);
    wb_xfer(1'b0, adr, '0, rdata);
  endtask

  task automatic wait_idle();
    logic [31:0] st;
    int          n;
    n = 0;
    wb_read(REG_STATUS, st);
    while (st[0] && n < 100) begin
      wb_read(REG_STATUS, st);
      n++;
    end
    if (st[0]) begin
      $display("ERROR at %0t: busy never fell after the job", $time);
      err_cnt++;
    end
  endtask

  task automatic wait_served(input int target);
    int n;
    n = 0;
    while (served < target && n < 300) begin
      @(posedge clk);
      n++;
    end
    if (served < target) begin
      $display("ERROR at %0t: DDR model served %0d of %0d requests", $time, served, target);
      err_cnt++;
    end
  endtask

  task automatic check_cmd(input int idx, input logic mode, input addr_t base, input len_t len);
    if (idx >= cmd_log.size()) begin
      $display("ERROR at %0t: DDR request %0d was never issued", $time, idx);
      err_cnt++;
    end else begin
      check("ddr_cmd.mode", 64'(cmd_log[idx].mode), 64'(mode));
      check("ddr_cmd.base", 64'(cmd_log[idx].base), 64'(base));
      check("ddr_cmd.len", 64'(cmd_log[idx].len), 64'(len));
    end
  endtask

  // word a lives in beat a/RATE, slice a%RATE
  function automatic word_t model_word(input addr_t a);
    beat_t b;
    addr_t ba;
    ba = a >> RATELOG;
    b  = ddr_mem[ba[7:0]];
    return b[a[RATELOG-1:0]*DWIDTH +: DWIDTH];
  endfunction

  task automatic read_check(input addr_t base, input int nwords);
    addr_t a;
    for (int i = 0; i < nwords; i++) begin
      a = base + addr_t'(i);
      @(posedge clk);
      mem <= '{we: 1'b0, addr: a, wdata: '0};
      @(posedge clk);
      @(negedge clk);
      check("mem_rdata", 64'(mem_rdata), 64'(model_word(a)));
    end
  endtask

  task automatic write_stream(input addr_t base, input int nwords, input int max_gap);
    int    gap;
    word_t w;
    for (int i = 0; i < nwords; i++) begin
      gap = (max_gap == 0) ? 0 : ($random(seed) & 32'h7fff_ffff) % (max_gap + 1);
      repeat (gap) begin
        @(posedge clk);
        mem <= '0;
      end
      w = word_t'($random(seed));
      sent_words[i] = w;
      @(posedge clk);
      mem <= '{we: 1'b1, addr: base + addr_t'(i), wdata: w};
    end
    @(posedge clk);
    mem <= '0;
  endtask

  // word j of beat k sits at bits j*DWIDTH
  task automatic check_drain(input addr_t beat_base, input int nbeats);
    beat_t exp;
    addr_t a;
    for (int k = 0; k < nbeats; k++) begin
      for (int j = 0; j < RATE; j++) begin
        exp[j*DWIDTH +: DWIDTH] = sent_words[k*RATE + j];
      end
      a = beat_base + addr_t'(k);
      check("drained beat", drained[a[7:0]], exp);
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    test_cnt++;
    if (err_cnt == errs_before) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // ========================================
  // tests
  // ========================================
  task automatic test_reset_regs();
    logic [31:0] v;
    int          e0;
    e0 = err_cnt;
    wb_read(REG_STATUS, v);
    check("status", 64'(v), 0);
    check("request count", 64'(cmd_log.size()), 0);
    wb_write(REG_BASE, 32'h1234);
    wb_write(REG_LEN, 32'h0040);
    wb_read(REG_BASE, v);
    check("base", 64'(v), 64'h1234);
    wb_read(REG_LEN, v);
    check("len", 64'(v), 64'h0040);
    wb_read(REG_CTRL, v);
    check("ctrl", 64'(v), 0);
    report_test("reset and registers", e0);
  endtask

  task automatic test_prefetch(input string name, input addr_t base, input len_t len,
                               input len_t exp_len);
    int e0;
    e0 = err_cnt;
    cmd_log.delete();
    wb_write(REG_BASE, 32'(base));
    wb_write(REG_LEN, 32'(len));
    wb_write(REG_CTRL, 32'h1);
    wait_idle();
    check("request count", 64'(cmd_log.size()), 1);
    check_cmd(0, DDR_READ, base >> RATELOG, exp_len);
    read_check(base, int'(len));
    report_test(name, e0);
  endtask

  task automatic test_write(input string name, input addr_t base, input len_t len,
                            input int max_gap, input int nbursts, input len_t last_len);
    int          e0;
    int          s0;
    logic [31:0] v;
    e0 = err_cnt;
    s0 = served;
    cmd_log.delete();
    wb_write(REG_BASE, 32'(base));
    wb_write(REG_LEN, 32'(len));
    wb_write(REG_CTRL, 32'h2);
    write_stream(base, int'(len), max_gap);
    wait_served(s0 + nbursts);
    wait_idle();
    check("request count", 64'(cmd_log.size()), 64'(nbursts));
    for (int b = 0; b < nbursts; b++) begin
      check_cmd(b, DDR_WRITE, (base >> RATELOG) + addr_t'(b * BURST_LEN),
                (b == nbursts - 1) ? last_len : len_t'(BURST_LEN));
    end
    check_drain(base >> RATELOG, int'(len) / RATE);
    wb_read(REG_STATUS, v);
    check("status", 64'(v), 0);
    report_test(name, e0);
  endtask

  initial begin
    wb_i = '0;
    mem  = '0;
    for (int i = 0; i < 256; i++) begin
      ddr_mem[i] = {$random(seed), $random(seed)};
    end
    @(posedge xrst);
    repeat (2) @(posedge clk);

    test_reset_regs();
    test_prefetch("prefetch len 32", 16'h0100, 16'd32, 16'd8);
    test_prefetch("prefetch len 12", 16'h0200, 16'd12, 16'd3);
    test_write("write len 64", 16'h0300, 16'd64, 0, 2, 16'd8);
    test_write("write len 40 with gaps", 16'h0380, 16'd40, 3, 2, 16'd2);

    repeat (4) @(posedge clk);
    err_cnt = err_cnt + u_dut.u_ctrl.u_assert.fail_cnt;
    $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* verilog.f */
ddr_buf_pkg.sv
ddr_buf_regs.sv
ddr_buf_ctrl.sv
word_packer.sv
sp_ram.sv
burst_bank.sv
ddr_buf_top.sv
tb_clkgen.sv
ddr_buf_assert.sv
tb_ddr_buf.sv

/* Makefile */
TOP = tb_ddr_buf

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -o sim_$(TOP)
	./obj_dir/sim_$(TOP) | tee sim.log
	grep -q -F '*** PASSED ***' sim.log

clean:
	rm -rf obj_dir sim.log
